// File: mini_cpu.f
+incdir+tb
logic/cpu_pkg.sv
logic/inst_if.sv
logic/prog_ram.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/exec_unit.sv
logic/cpu_top.sv
tb/cpu_tb.sv

// File: tb/cpu_model.svh
typedef logic [25:0] store_t;  // {addr, data}

cpu_pkg::word_t model_mem [1 << $bits(cpu_pkg::addr_t)];
cpu_pkg::word_t model_regs [cpu_pkg::NUM_REGS];
store_t         exp_q [$];  // stores the program must make

task automatic reset_model();
  for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
    model_regs[i] = '0;
  end
endtask

task automatic run_model();  // one instruction at a time in program order
  cpu_pkg::addr_t    pc;
  cpu_pkg::addr_t    a;
  cpu_pkg::word_t    w0;
  cpu_pkg::word_t    w1;
  cpu_pkg::reg_idx_t r;
  logic              stop;
  int                steps;
  begin
    pc    = cpu_pkg::addr_t'(PROG_START);
    stop  = 1'b0;
    steps = 0;
    exp_q.delete();
    while (!stop && steps < MODEL_STEPS) begin
      w0 = model_mem[pc];
      a  = pc + 1'b1;
      w1 = model_mem[a];
      r  = w0[4:0];   // upper bits of the register byte ignored
      a  = w1[9:0];   // address operand
      pc = pc + 2'd2;
      steps++;
      case (w0[15:8])
        cpu_pkg::OP_JMP:       pc = a;
        cpu_pkg::OP_RAM2REG:   model_regs[r] = model_mem[a];
        cpu_pkg::OP_REG2RAM: begin
          model_mem[a] = model_regs[r];
          exp_q.push_back({a, model_regs[r]});
        end
        cpu_pkg::OP_NUM2REG:   model_regs[r] = w1;
        cpu_pkg::OP_REG_PLUS:  model_regs[r] = model_regs[r] + w1;  // wraps at 16 bits
        cpu_pkg::OP_REG_MINUS: model_regs[r] = model_regs[r] - w1;
        cpu_pkg::OP_EXIT:      stop = 1'b1;
        default: ;  // unknown opcode has no effect
      endcase
    end
    if (!stop) begin
      $display("model found no EXIT within %0d instructions", MODEL_STEPS);
    end
  end
endtask

// File: tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

  localparam int PROG_START  = 46;
  localparam int QUEUE_DEPTH = 4;
  localparam int PERIOD      = 8;
  localparam int DATA_BASE   = 512;
  localparam int DATA_WORDS  = 64;    // window used by loads and stores
  localparam int MODEL_STEPS = 4096;

  localparam int NUM_PAIRS      = 8;
  localparam int ARITH_STEPS    = 6;
  localparam int COPY_PAIRS     = 8;
  localparam int JUMP_LEN       = 10;
  localparam int RAND_LEN       = 200;
  localparam int PRESSURE_LOADS = 32;
  localparam int TOTAL_INSTS = (2 * NUM_PAIRS + 1) + (3 * ARITH_STEPS + 1)
                             + (2 * COPY_PAIRS + 1) + JUMP_LEN + RAND_LEN
                             + (PRESSURE_LOADS + PRESSURE_LOADS / 2 + 1);
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_INSTS;

  logic           clka;
  logic           rst;
  logic           start;
  logic           load_en;
  cpu_pkg::addr_t load_addr;
  cpu_pkg::word_t load_data;
  logic           busy;
  logic           st_valid;
  cpu_pkg::addr_t st_addr;
  cpu_pkg::word_t st_data;

  integer         seed;
  string          cur_test;
  int             pass_count;
  int             fail_count;
  cpu_pkg::word_t prog [$];

  `include "cpu_model.svh"

  store_t got_q [$];  // stores seen on the st_ ports

  cpu_top #(.PROG_START(PROG_START), .QUEUE_DEPTH(QUEUE_DEPTH)) cpu_top_inst (
    .clka      (clka),
    .rst       (rst),
    .start     (start),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .busy      (busy),
    .st_valid  (st_valid),
    .st_addr   (st_addr),
    .st_data   (st_data)
  );

  initial begin
    clka = 1'b0;
    forever #(PERIOD / 2) clka = ~clka;
  end

  always @(posedge clka) begin
    if (rst && st_valid) begin
      got_q.push_back({st_addr, st_data});
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clka);
    $display("watchdog expired during %s, busy never fell", cur_test);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // address operand with junk in the bits above the address
  function automatic cpu_pkg::word_t data_addr();
    data_addr = {6'(rand_below(64)), 10'(DATA_BASE + rand_below(DATA_WORDS))};
  endfunction

  function automatic cpu_pkg::word_t jump_target(input int idx);
    jump_target = {6'(rand_below(64)), 10'(PROG_START + 2 * idx)};
  endfunction

  function automatic cpu_pkg::word_t near_edge();
    int unsigned k;
    begin
      k = rand_below(8);
      near_edge = (rand_below(2) == 0) ? 16'(k) : 16'hFFFF - 16'(k);
    end
  endfunction

  task automatic add_inst(input logic [7:0] op, input int r, input cpu_pkg::word_t val);
    prog.push_back({op, 3'(rand_below(8)), 5'(r)});  // top bits of reg byte are noise
    prog.push_back(val);
  endtask

  task automatic load_word(input int addr, input cpu_pkg::word_t data);
    @(posedge clka);
    load_en   <= 1'b1;
    load_addr <= cpu_pkg::addr_t'(addr);
    load_data <= data;
    model_mem[cpu_pkg::addr_t'(addr)] = data;
  endtask

  task automatic run_test(input string name);
    int     errors;
    store_t e;
    store_t g;
    begin
      cur_test = name;
      errors   = 0;
      for (int i = 0; i < DATA_WORDS; i++) begin
        load_word(DATA_BASE + i, 16'($random(seed)));
      end
      for (int i = 0; i < prog.size(); i++) begin
        load_word(PROG_START + i, prog[i]);
      end
      @(posedge clka);
      load_en <= 1'b0;
      run_model();
      got_q.delete();
      start <= 1'b1;
      @(posedge clka);
      start <= 1'b0;
      @(posedge clka);
      if (busy !== 1'b1) begin
        errors++;
        $display("%s: busy did not rise after start", name);
      end
      while (busy === 1'b1) @(posedge clka);
      @(posedge clka);  // last strobe settles
      if (got_q.size() != exp_q.size()) begin
        errors++;
        $display("%s: %0d stores expected but %0d seen", name, exp_q.size(), got_q.size());
      end
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
        e = exp_q[i];
        g = got_q[i];
        if (g !== e) begin
          if (errors == 0) begin
            $display("Fail %s expected %h/%h actual %h/%h", name, e[25:16], e[15:0],
                     g[25:16], g[15:0]);
          end
          errors++;
        end
      end
      if (errors == 0) begin
        pass_count++;
        $display("%s passed, %0d stores", name, got_q.size());
      end else begin
        fail_count++;
        $display("%s failed, %0d errors", name, errors);
      end
    end
  endtask

  task automatic build_random();
    int unsigned k;
    int unsigned span;
    begin
      prog.delete();
      for (int i = 0; i < RAND_LEN - 1; i++) begin
        k = rand_below(16);
        case (k)
          0, 1, 2, 15: add_inst(cpu_pkg::OP_NUM2REG, rand_below(32), 16'($random(seed)));
          3, 4:        add_inst(cpu_pkg::OP_REG_PLUS, rand_below(32), 16'($random(seed)));
          5, 6:        add_inst(cpu_pkg::OP_REG_MINUS, rand_below(32), 16'($random(seed)));
          7, 8:        add_inst(cpu_pkg::OP_RAM2REG, rand_below(32), data_addr());
          9, 10, 11:   add_inst(cpu_pkg::OP_REG2RAM, rand_below(32), data_addr());
          12: begin
            span = RAND_LEN - 1 - i;  // forward only and at most up to EXIT
            if (span > 8) span = 8;
            add_inst(cpu_pkg::OP_JMP, rand_below(32), jump_target(i + 1 + rand_below(span)));
          end
          default: add_inst(8'h20 + 8'(rand_below(8'hC0)), rand_below(32),
                            16'($random(seed)));
        endcase
      end
      add_inst(cpu_pkg::OP_EXIT, 0, '0);
    end
  endtask

  initial begin
    int r;
    seed       = 32'h5485;
    cur_test   = "reset";
    pass_count = 0;
    fail_count = 0;
    rst        = 1'b0;
    start      = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    reset_model();
    repeat (10) @(posedge clka);
    rst <= 1'b1;

    prog.delete();
    for (int i = 0; i < NUM_PAIRS; i++) begin
      add_inst(cpu_pkg::OP_NUM2REG, 2 * i + 1, 16'($random(seed)));
    end
    for (int i = 0; i < NUM_PAIRS; i++) begin
      add_inst(cpu_pkg::OP_REG2RAM, 2 * i + 1, data_addr());
    end
    add_inst(cpu_pkg::OP_EXIT, 0, '0);
    run_test("num2reg_store");

    prog.delete();
    for (int i = 0; i < ARITH_STEPS; i++) begin
      r = rand_below(32);
      add_inst(cpu_pkg::OP_NUM2REG, r, near_edge());
      add_inst(rand_below(2) ? cpu_pkg::OP_REG_PLUS : cpu_pkg::OP_REG_MINUS, r, near_edge());
      add_inst(cpu_pkg::OP_REG2RAM, r, data_addr());
    end
    add_inst(cpu_pkg::OP_EXIT, 0, '0);
    run_test("arith_wrap");

    prog.delete();
    for (int i = 0; i < COPY_PAIRS; i++) begin
      r = rand_below(32);
      add_inst(cpu_pkg::OP_RAM2REG, r, data_addr());
      add_inst(cpu_pkg::OP_REG2RAM, r, data_addr());
    end
    add_inst(cpu_pkg::OP_EXIT, 0, '0);
    run_test("ram_to_reg");

    prog.delete();
    r = rand_below(32);
    add_inst(cpu_pkg::OP_NUM2REG, r, 16'($random(seed)));
    add_inst(cpu_pkg::OP_REG2RAM, r, 16'(DATA_BASE));
    add_inst(cpu_pkg::OP_JMP, 0, jump_target(7));  // lands on the store to base + 5
    for (int i = 1; i <= 6; i++) begin
      add_inst(cpu_pkg::OP_REG2RAM, r, 16'(DATA_BASE + i));  // first four skipped
    end
    add_inst(cpu_pkg::OP_EXIT, 0, '0);
    run_test("jump_skip");

    build_random();
    run_test("random_program");

    prog.delete();
    for (int i = 0; i < PRESSURE_LOADS; i++) begin
      add_inst(cpu_pkg::OP_RAM2REG, i % 32, data_addr());
    end
    for (int i = 0; i < PRESSURE_LOADS / 2; i++) begin
      add_inst(cpu_pkg::OP_REG2RAM, (3 * i) % 32, data_addr());
    end
    add_inst(cpu_pkg::OP_EXIT, 0, '0);
    run_test("queue_pressure");

    $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
  parameter int unsigned PROG_START  = 46,
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic           clka,
  input  logic           rst,
  input  logic           start,
  input  logic           load_en,
  input  cpu_pkg::addr_t load_addr,
  input  cpu_pkg::word_t load_data,
  output logic           busy,
  output logic           st_valid,
  output cpu_pkg::addr_t st_addr,
  output cpu_pkg::word_t st_data
);

  cpu_pkg::addr_t addr_a;
  logic           we_a;
  cpu_pkg::word_t wr_data_a;
  cpu_pkg::word_t rd_data_a;
  cpu_pkg::addr_t rd_addr_b;
  cpu_pkg::word_t rd_data_b;
  logic           done;

  inst_if push_if ();  // fetch to queue
  inst_if pop_if ();   // queue to exec

  prog_ram prog_ram_inst (
    .clka      (clka),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .addr_a    (addr_a),
    .we_a      (we_a),
    .wr_data_a (wr_data_a),
    .rd_data_a (rd_data_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_b (rd_data_b)
  );

  fetch_unit #(.PROG_START(PROG_START)) fetch_unit_inst (
    .clka      (clka),
    .rst       (rst),
    .start     (start),
    .done      (done),
    .rd_addr_b (rd_addr_b),
    .rd_data_b (rd_data_b),
    .push      (push_if.producer)
  );

  inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_inst (
    .clka (clka),
    .rst  (rst),
    .wr   (push_if.consumer),
    .rd   (pop_if.producer)
  );

  exec_unit exec_unit_inst (
    .clka      (clka),
    .rst       (rst),
    .start     (start),
    .pop       (pop_if.consumer),
    .addr_a    (addr_a),
    .we_a      (we_a),
    .wr_data_a (wr_data_a),
    .rd_data_a (rd_data_a),
    .busy      (busy),
    .done      (done),
    .st_valid  (st_valid),
    .st_addr   (st_addr),
    .st_data   (st_data)
  );

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
  input  logic            clka,
  input  logic            rst,
  input  logic            start,
  inst_if.consumer        pop,
  output cpu_pkg::addr_t  addr_a,
  output logic            we_a,
  output cpu_pkg::word_t  wr_data_a,
  input  cpu_pkg::word_t  rd_data_a,
  output logic            busy,
  output logic            done,
  output logic            st_valid,
  output cpu_pkg::addr_t  st_addr,
  output cpu_pkg::word_t  st_data
);

  cpu_pkg::exec_state_e state;
  cpu_pkg::word_t       regs [cpu_pkg::NUM_REGS];
  cpu_pkg::reg_idx_t    ld_reg;
  logic                 retire;

  assign pop.ready = (state == cpu_pkg::EX_RUN);  // low while a load completes
  assign retire    = pop.valid && pop.ready;

  // port a follows the head item and the read lands on the pop edge
  assign addr_a    = cpu_pkg::addr_t'(pop.item.value);
  assign wr_data_a = regs[pop.item.reg_num];
  assign we_a      = retire && (pop.item.op == cpu_pkg::OP_REG2RAM);

  assign busy = (state == cpu_pkg::EX_RUN) || (state == cpu_pkg::EX_LOAD_WAIT);
  assign done = (state == cpu_pkg::EX_DONE);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= cpu_pkg::EX_IDLE;
      st_valid <= 1'b0;
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      st_valid <= we_a;  // one beat per store
      case (state)
        cpu_pkg::EX_IDLE, cpu_pkg::EX_DONE: begin
          if (start) begin
            state <= cpu_pkg::EX_RUN;
          end
        end
        cpu_pkg::EX_RUN: begin
          if (pop.valid) begin
            case (pop.item.op)
              cpu_pkg::OP_NUM2REG:   regs[pop.item.reg_num] <= pop.item.value;
              cpu_pkg::OP_REG_PLUS:
                regs[pop.item.reg_num] <= regs[pop.item.reg_num] + pop.item.value;
              cpu_pkg::OP_REG_MINUS:
                regs[pop.item.reg_num] <= regs[pop.item.reg_num] - pop.item.value;
              cpu_pkg::OP_RAM2REG:   state <= cpu_pkg::EX_LOAD_WAIT;
              cpu_pkg::OP_EXIT:      state <= cpu_pkg::EX_DONE;
              default: ;  // stores leave on port a and others do nothing
            endcase
          end
        end
        cpu_pkg::EX_LOAD_WAIT: begin
          regs[ld_reg] <= rd_data_a;
          state        <= cpu_pkg::EX_RUN;
        end
        default: state <= cpu_pkg::EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (retire) begin
      ld_reg <= pop.item.reg_num;
    end
    st_addr <= addr_a;
    st_data <= wr_data_a;
  end

  // busy only ends after an EXIT from the queue retired
  a_busy_exit: assert property (
    @(posedge clka) disable iff (!rst)
    $fell(busy) |-> $past(retire && pop.item.op == cpu_pkg::OP_EXIT)
  ) else $error("busy fell without EXIT");

endmodule

// File: logic/inst_queue.sv
`timescale 1ns/100ps

module inst_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic     clka,
  input  logic     rst,
  inst_if.consumer wr,
  inst_if.producer rd
);

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

  cpu_pkg::inst_t   mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign wr.ready = (count != (PTR_W + 1)'(QUEUE_DEPTH));  // not full
  assign rd.valid = (count != '0);                         // not empty
  assign rd.item  = mem[rd_ptr];

  assign do_push = wr.valid && wr.ready;
  assign do_pop  = rd.valid && rd.ready;

  always_ff @(posedge clka) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (do_push) begin
      mem[wr_ptr] <= wr.item;
    end
  end

  a_no_overflow: assert property (
    @(posedge clka) disable iff (!rst) count <= (PTR_W + 1)'(QUEUE_DEPTH)
  ) else $error("queue count above depth");

  // the head must not move while the queue is empty
  a_no_underflow: assert property (
    @(posedge clka) disable iff (!rst) count == '0 |=> rd_ptr == $past(rd_ptr)
  ) else $error("queue popped while empty");

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
  parameter int unsigned PROG_START = 46
) (
  input  logic           clka,
  input  logic           rst,
  input  logic           start,
  input  logic           done,
  output cpu_pkg::addr_t rd_addr_b,
  input  cpu_pkg::word_t rd_data_b,
  inst_if.producer       push
);

  typedef enum logic [2:0] {F_IDLE, F_REQ, F_OP, F_VAL, F_HOLD} fetch_state_e;

  fetch_state_e      state;
  cpu_pkg::addr_t    pc;
  logic [7:0]        op_q;
  cpu_pkg::reg_idx_t reg_q;
  cpu_pkg::word_t    val_q;
  cpu_pkg::inst_t    cur_item;
  logic              slot_free;
  logic              fire;

  assign rd_addr_b = pc;  // ram reads pc every cycle
  assign slot_free = !push.valid || push.ready;
  assign fire      = (state == F_VAL || state == F_HOLD) && op_q != cpu_pkg::OP_JMP
                     && slot_free;

  always_comb begin
    cur_item.op      = op_q;
    cur_item.reg_num = reg_q;
    cur_item.value   = (state == F_HOLD) ? val_q : rd_data_b;  // word 1 arrives in F_VAL
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= F_IDLE;
      pc         <= '0;
      push.valid <= 1'b0;
    end else if (start) begin
      state      <= F_REQ;
      pc         <= cpu_pkg::addr_t'(PROG_START);
      push.valid <= 1'b0;
    end else if (done) begin
      state      <= F_IDLE;  // run over
      push.valid <= 1'b0;
    end else begin
      if (push.valid && push.ready) begin
        push.valid <= 1'b0;
      end
      case (state)
        F_REQ, F_OP: begin
          pc    <= pc + 1'b1;
          state <= (state == F_REQ) ? F_OP : F_VAL;
        end
        F_VAL, F_HOLD: begin
          if (op_q == cpu_pkg::OP_JMP) begin
            pc    <= cpu_pkg::addr_t'(cur_item.value);
            state <= F_REQ;  // refetch at target
          end else if (fire) begin
            push.valid <= 1'b1;
            if (op_q == cpu_pkg::OP_EXIT) begin
              state <= F_IDLE;  // stop until next start
            end else begin
              pc    <= pc + 1'b1;  // next word 0 already requested
              state <= F_OP;
            end
          end else begin
            state <= F_HOLD;  // queue full, keep pc
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == F_OP) begin
      op_q  <= rd_data_b[15:8];
      reg_q <= rd_data_b[4:0];
    end
    if (state == F_VAL) begin
      val_q <= rd_data_b;
    end
    if (fire) begin
      push.item <= cur_item;
    end
  end

  // a pushed item stays put until the queue takes it
  a_push_hold: assert property (
    @(posedge clka) disable iff (!rst)
    push.valid && !push.ready |=> push.valid && $stable(push.item)
  ) else $error("fetch dropped or changed an item before transfer");

endmodule

// File: logic/prog_ram.sv
`timescale 1ns/100ps

module prog_ram (
  input  logic           clka,
  input  logic           load_en,
  input  cpu_pkg::addr_t load_addr,
  input  cpu_pkg::word_t load_data,
  input  cpu_pkg::addr_t addr_a,
  input  logic           we_a,
  input  cpu_pkg::word_t wr_data_a,
  output cpu_pkg::word_t rd_data_a,
  input  cpu_pkg::addr_t rd_addr_b,
  output cpu_pkg::word_t rd_data_b
);

  localparam int unsigned DEPTH = 1 << $bits(cpu_pkg::addr_t);

  cpu_pkg::word_t mem [DEPTH];

  // load port wins over the execute port
  always_ff @(posedge clka) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (we_a) begin
      mem[addr_a] <= wr_data_a;
    end
  end

  // both reads registered, data one cycle after address
  always_ff @(posedge clka) begin
    rd_data_a <= mem[addr_a];
    rd_data_b <= mem[rd_addr_b];
  end

  // program loading only happens while the core is stopped,
  // so the execute port must never write at the same time
  a_load_idle: assert property (
    @(posedge clka) load_en |-> !we_a
  ) else $error("load port used while execute port writes");

endmodule

// File: logic/inst_if.sv
`timescale 1ns/100ps

// one instruction item with a valid/ready pair
// the item moves on an edge where valid and ready are both high
interface inst_if;

  logic           valid;  // held until accepted
  logic           ready;
  cpu_pkg::inst_t item;

  modport producer (
    output valid,
    output item,
    input  ready
  );

  modport consumer (
    input  valid,
    input  item,
    output ready
  );

endinterface

// File: logic/cpu_pkg.sv
package cpu_pkg;

  typedef logic [9:0]  addr_t;     // ram word address
  typedef logic [15:0] word_t;     // data and operand word
  typedef logic [4:0]  reg_idx_t;  // low bits of the register byte

  localparam int unsigned NUM_REGS = 32;

  // opcode byte of instruction word 0
  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,
    OP_RAM2REG   = 8'd2,
    OP_REG2RAM   = 8'd3,
    OP_NUM2REG   = 8'd4,
    OP_REG_PLUS  = 8'd5,
    OP_REG_MINUS = 8'd6,
    OP_EXIT      = 8'd17
  } opcode_e;

  // one decoded instruction as it moves through the queue
  typedef struct packed {
    logic [7:0] op;       // raw byte, unknown codes pass through
    reg_idx_t   reg_num;
    word_t      value;    // word 1 of the instruction
  } inst_t;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_LOAD_WAIT,   // ram read in flight
    EX_DONE         // exit retired
  } exec_state_e;

endpackage
